//--- hw/button_edges.sv
`timescale 1ns/1ps

// one press pulse per rising level, so a held button acts once
module button_edges import phone_ui_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  btn_t levels,  // raw button levels
	output btn_t presses  // one-cycle pulses
);

	btn_t levels_q; // previous sample of every button

	//////////////////////////////////////////////////
	// rising edge detect
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			levels_q <= '0;
			presses  <= '0;
		end else begin
			levels_q <= levels;
			// high now, low on the last sample
			presses  <= levels & ~levels_q;
		end
	end

endmodule

//--- hw/call_control.sv
`timescale 1ns/1ps

// call state machine and menu navigator
module call_control import phone_ui_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  btn_t        presses,
	input  logic [7:0]  switches,    // number to dial
	input  app_evt_t    app_evt,
	input  logic        ring_expired,
	output logic        ring_start,
	output vol_req_t    vol_req,
	output call_state_t call_state,
	output menu_item_t  menu_item,
	output net_cmd_t    net_cmd,
	output logic [7:0]  dial_number
);

	logic       select;     // enter and right both pick an item
	vol_req_t   vol_step;   // requests while on the change volume screen
	logic       vol_exit;   // leave change volume
	menu_item_t vol_parent; // where change volume returns to

	//////////////////////////////////////////////////
	// change volume screen, shared by idle and busy
	//////////////////////////////////////////////////

	always_comb begin
		select           = presses.enter | presses.right;
		vol_step         = '0;
		vol_step.inc     = presses.up;
		vol_step.dec     = presses.down;
		vol_step.commit  = presses.enter;
		vol_step.discard = presses.left; // back out drops the change
		vol_exit         = presses.enter | presses.left;
		vol_parent       = (call_state == st_busy) ? mi_set_volume : mi_volume;
	end

	//////////////////////////////////////////////////
	// state and menu
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			call_state  <= st_init;
			menu_item   <= mi_def_init;
			net_cmd     <= cmd_none;
			dial_number <= '0;
			ring_start  <= 1'b0;
			vol_req     <= '0;
		end else begin
			// strobes default low
			net_cmd    <= cmd_none;
			ring_start <= 1'b0;
			vol_req    <= '0;

			case (call_state)
				st_init: begin
					if (presses.enter) begin
						call_state <= st_idle;
						menu_item  <= mi_welcome;
					end
				end

				st_idle: begin
					if (app_evt == evt_incoming_call) begin // ring wins over menu
						call_state <= st_incoming;
						menu_item  <= mi_def_incoming;
						ring_start <= 1'b1;
					end else begin
						case (menu_item)
							mi_welcome: if (select) menu_item <= mi_call_number;
							mi_call_number: begin
								if (presses.up || presses.down)
									menu_item <= mi_volume; // two items, wraps
								else if (select)
									menu_item <= mi_dialing;
							end
							mi_volume: begin
								if (presses.up || presses.down)
									menu_item <= mi_call_number;
								else if (select)
									menu_item <= mi_change_vol;
							end
							mi_dialing: begin
								if (presses.enter) begin
									dial_number <= switches;
									net_cmd     <= cmd_make_call;
									call_state  <= st_outgoing;
									menu_item   <= mi_def_outgoing;
								end else if (presses.left) begin
									menu_item <= mi_call_number;
								end
							end
							mi_change_vol: begin
								vol_req <= vol_step;
								if (vol_exit)
									menu_item <= vol_parent;
							end
							default: ;
						endcase
					end
				end

				st_incoming: begin
					if (app_evt == evt_connected) begin
						call_state <= st_busy;
						menu_item  <= mi_def_busy;
					end else if (app_evt == evt_call_ended) begin
						call_state <= st_idle;
						menu_item  <= mi_call_number;
					end else if (ring_expired && !ring_start) begin
						// first cycle still sees the old expiry from ring_timer
						net_cmd    <= cmd_stop_call;
						call_state <= st_idle;
						menu_item  <= mi_call_number;
					end else if (presses.down) begin
						case (menu_item)
							mi_def_incoming: menu_item <= mi_accept;
							mi_accept:       menu_item <= mi_reject;
							default:         menu_item <= mi_def_incoming;
						endcase
					end else if (presses.up) begin
						case (menu_item)
							mi_def_incoming: menu_item <= mi_reject;
							mi_reject:       menu_item <= mi_accept;
							default:         menu_item <= mi_def_incoming;
						endcase
					end else if (presses.enter) begin
						// wait here for the app to confirm
						net_cmd <= (menu_item == mi_reject) ? cmd_stop_call : cmd_accept_call;
					end
				end

				st_outgoing: begin
					if (app_evt == evt_connected) begin
						call_state <= st_busy;
						menu_item  <= mi_def_busy;
					end else if (app_evt == evt_failed || app_evt == evt_call_ended) begin
						call_state <= st_idle;
						menu_item  <= mi_call_number;
					end else if (presses.up || presses.down) begin
						menu_item <= (menu_item == mi_end_call) ? mi_def_outgoing : mi_end_call;
					end else if (presses.enter && menu_item == mi_end_call) begin
						net_cmd <= cmd_stop_call; // hang up, app reports call_ended
					end
				end

				st_busy: begin
					if (app_evt == evt_call_ended) begin
						call_state <= st_idle;
						menu_item  <= mi_call_number;
					end else begin
						case (menu_item)
							mi_def_busy: begin
								if (presses.down)
									menu_item <= mi_end_call_b;
								else if (presses.up)
									menu_item <= mi_set_volume;
							end
							mi_end_call_b: begin
								if (presses.down)
									menu_item <= mi_set_volume;
								else if (presses.up)
									menu_item <= mi_def_busy;
								else if (presses.enter)
									net_cmd <= cmd_stop_call;
							end
							mi_set_volume: begin
								if (presses.down)
									menu_item <= mi_def_busy; // wrap
								else if (presses.up)
									menu_item <= mi_end_call_b;
								else if (presses.enter)
									menu_item <= mi_change_vol;
							end
							mi_change_vol: begin
								vol_req <= vol_step;
								if (vol_exit)
									menu_item <= vol_parent;
							end
							default: menu_item <= mi_def_busy;
						endcase
					end
				end

				default: begin // unused code, restart
					call_state <= st_init;
					menu_item  <= mi_def_init;
				end
			endcase
		end
	end

endmodule

//--- hw/menu_text_table.sv
`timescale 1ns/1ps

// text string for each menu item, start pulse on every change
module menu_text_table import phone_ui_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  menu_item_t menu_item,
	output text_ref_t  text_ref,
	output logic       txt_start // one-cycle, display reload
);

	menu_item_t item_q;  // last item seen
	text_ref_t  lut_ref;
	logic       lut_hit; // item has a string

	//////////////////////////////////////////////////
	// string table, text rom offsets
	//////////////////////////////////////////////////

	always_comb begin
		lut_hit = 1'b1;
		lut_ref = '0;
		case (menu_item)
			mi_def_init:     lut_ref = '{addr: 11'd0,   len: 11'd45}; // press enter to start
			mi_welcome:      lut_ref = '{addr: 11'd45,  len: 11'd7};
			mi_call_number:  lut_ref = '{addr: 11'd52,  len: 11'd11};
			mi_volume:       lut_ref = '{addr: 11'd63,  len: 11'd20};
			mi_def_incoming: lut_ref = '{addr: 11'd360, len: 11'd13};
			mi_accept:       lut_ref = '{addr: 11'd374, len: 11'd20};
			mi_reject:       lut_ref = '{addr: 11'd395, len: 11'd20};
			mi_def_outgoing: lut_ref = '{addr: 11'd434, len: 11'd7};  // calling
			mi_end_call,
			mi_end_call_b:   lut_ref = '{addr: 11'd442, len: 11'd8};
			mi_def_busy:     lut_ref = '{addr: 11'd489, len: 11'd12}; // current call
			default:         lut_hit = 1'b0; // dialing, volume screens
		endcase
	end

	//////////////////////////////////////////////////
	// change detect
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			item_q    <= mi_def_init; // matches call_control reset
			txt_start <= 1'b0;
			text_ref  <= '{addr: 11'd0, len: 11'd45};
		end else begin
			item_q    <= menu_item;
			txt_start <= (menu_item != item_q);
			if (menu_item != item_q && lut_hit)
				text_ref <= lut_ref; // no string, keep old text
		end
	end

endmodule

//--- hw/phone_ui_pkg.sv
package phone_ui_pkg;

	//////////////////////////////////////////////////
	// states and menu items
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		st_init     = 3'd0, // waiting for first enter
		st_idle     = 3'd1, // no call, main menu
		st_incoming = 3'd2, // phone ringing
		st_outgoing = 3'd3, // dialed, waiting on far end
		st_busy     = 3'd4  // call in progress
	} call_state_t;

	// codes follow the old firmware numbering
	typedef enum logic [5:0] {
		mi_call_number  = 6'd0,
		mi_volume       = 6'd1,
		mi_dialing      = 6'd7,
		mi_change_vol   = 6'd8,
		mi_def_incoming = 6'd32,
		mi_accept       = 6'd33,
		mi_reject       = 6'd34,
		mi_def_outgoing = 6'd36,
		mi_end_call     = 6'd37,
		mi_def_busy     = 6'd38,
		mi_end_call_b   = 6'd39,
		mi_set_volume   = 6'd40,
		mi_welcome      = 6'd50,
		mi_def_init     = 6'd51
	} menu_item_t;

	//////////////////////////////////////////////////
	// ui <-> application layer
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		cmd_none        = 3'd0,
		cmd_make_call   = 3'd1, // dial_number valid with it
		cmd_stop_call   = 3'd2,
		cmd_accept_call = 3'd3
	} net_cmd_t;

	typedef enum logic [2:0] {
		evt_none          = 3'd0,
		evt_connected     = 3'd1,
		evt_failed        = 3'd4, // dropped or never went through
		evt_incoming_call = 3'd5,
		evt_call_ended    = 3'd6
	} app_evt_t;

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic enter;
	} btn_t; // levels at the pins, pulses after edge detect

	typedef struct packed {
		logic inc;
		logic dec;
		logic commit;
		logic discard;
	} vol_req_t;

	typedef struct packed {
		logic [10:0] addr; // start of string in text rom
		logic [10:0] len;  // characters
	} text_ref_t;

	localparam logic [4:0] vol_default = 5'd16;
	localparam logic [4:0] vol_max     = 5'd31;

endpackage

//--- hw/phone_ui_top.sv
`timescale 1ns/1ps

// desk phone ui, buttons in, commands and display refs out
module phone_ui_top import phone_ui_pkg::*; #(
	parameter int tick_div   = 27000000,
	parameter int ring_ticks = 30
) (
	input  logic        clk,
	input  logic        rst,
	input  btn_t        buttons,
	input  logic [7:0]  switches,
	input  app_evt_t    app_evt,
	output call_state_t call_state,
	output menu_item_t  menu_item,
	output net_cmd_t    net_cmd,
	output logic [7:0]  dial_number,
	output logic [4:0]  volume,
	output text_ref_t   text_ref,
	output logic        txt_start
);

	btn_t     presses;
	logic     ring_start;
	logic     ring_expired;
	vol_req_t vol_req;

	button_edges edges_i (
		.clk(clk), .rst(rst), .levels(buttons), .presses(presses)
	);

	ring_timer #(.tick_div(tick_div), .ring_ticks(ring_ticks)) ring_i (
		.clk(clk), .rst(rst), .ring_start(ring_start), .ring_expired(ring_expired)
	);

	volume_control vol_i (
		.clk(clk), .rst(rst), .vol_req(vol_req), .volume(volume)
	);

	call_control ctrl_i (
		.clk(clk), .rst(rst), .presses(presses), .switches(switches),
		.app_evt(app_evt), .ring_expired(ring_expired), .ring_start(ring_start),
		.vol_req(vol_req), .call_state(call_state), .menu_item(menu_item),
		.net_cmd(net_cmd), .dial_number(dial_number)
	);

	menu_text_table text_i (
		.clk(clk), .rst(rst), .menu_item(menu_item),
		.text_ref(text_ref), .txt_start(txt_start)
	);

endmodule

//--- hw/ring_timer.sv
`timescale 1ns/1ps

// free running prescaler plus tick countdown for unanswered calls
module ring_timer import phone_ui_pkg::*; #(
	parameter int tick_div   = 27000000, // clk cycles per tick
	parameter int ring_ticks = 30        // ticks before giving up
) (
	input  logic clk,
	input  logic rst,
	input  logic ring_start,  // reload, one-cycle
	output logic ring_expired // level until next start
);

	localparam int pre_w = (tick_div > 1) ? $clog2(tick_div) : 1;
	localparam int cnt_w = $clog2(ring_ticks + 1);

	logic [pre_w-1:0] pre_cnt;
	logic             tick;
	logic [cnt_w-1:0] ticks_left; // zero means idle

	//////////////////////////////////////////////////
	// prescaler
	//////////////////////////////////////////////////

	assign tick = (pre_cnt == pre_w'(tick_div - 1));

	always_ff @(posedge clk) begin
		if (rst || tick)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 1'b1;
	end

	//////////////////////////////////////////////////
	// countdown
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ticks_left   <= '0;
			ring_expired <= 1'b0;
		end else if (ring_start) begin
			ticks_left   <= cnt_w'(ring_ticks); // phase not aligned to prescaler
			ring_expired <= 1'b0;
		end else if (tick && ticks_left != '0) begin
			ticks_left <= ticks_left - 1'b1;
			if (ticks_left == cnt_w'(1))
				ring_expired <= 1'b1; // last tick gone
		end
	end

endmodule

//--- hw/volume_control.sv
`timescale 1ns/1ps

// headphone volume with a pending change, applied only on commit
module volume_control import phone_ui_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  vol_req_t   vol_req,
	output logic [4:0] volume
);

	logic signed [5:0] pending; // -31..+31
	logic signed [6:0] target;  // volume the user would get

	assign target = $signed({2'b00, volume}) + pending;

	always_ff @(posedge clk) begin
		if (rst) begin
			volume  <= vol_default;
			pending <= '0;
		end else if (vol_req.commit) begin
			volume  <= target[4:0]; // already clamped by inc/dec
			pending <= '0;
		end else if (vol_req.discard) begin
			pending <= '0;
		end else if (vol_req.inc) begin
			if (target < $signed({2'b00, vol_max}))
				pending <= pending + 6'sd1;
		end else if (vol_req.dec) begin
			if (target > 7'sd0) // floor at mute
				pending <= pending - 6'sd1;
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the phone ui testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module phone_ui_tb -f tb.f

out=$(./obj_dir/Vphone_ui_tb)
echo "$out"

if grep -qx "Test OK" <<< "$out"; then
	exit 0
fi
exit 1

//--- tb.f
hw/phone_ui_pkg.sv
hw/button_edges.sv
hw/ring_timer.sv
hw/volume_control.sv
hw/call_control.sv
hw/menu_text_table.sv
hw/phone_ui_top.sv
testbench/phone_ui_tb.sv

//--- testbench/phone_ui_stimulus.txt
// all hex: test action arg | expected state item volume addr len cmd txt_start_pulses
// action 0 check, 1 press (arg repeats<<8 | up 10 down 08 left 04 right 02 enter 01),
// 2 switches, 3 event, 4 wait for state, 5 long hold, ff end
// reset and init
1 0 0    0 33 10 0   2d 0 0
1 1 1    1 32 10 2d  7  0 1
// main menu, held button moves once
2 1 1    1 0  10 34  b  0 1
2 1 8    1 1  10 3f  14 0 1
2 1 8    1 0  10 34  b  0 1
2 5 8    1 1  10 3f  14 0 1
2 1 10   1 0  10 34  b  0 1
// outgoing call
3 2 a5   1 0  10 34  b  0 0
3 1 1    1 7  10 34  b  0 1
3 1 1    3 24 10 1b2 7  1 1
3 3 1    4 26 10 1e9 c  0 1
3 1 8    4 27 10 1ba 8  0 1
3 1 1    4 27 10 1ba 8  2 0
3 3 6    1 0  10 34  b  0 1
// volume, clamp and discard
4 1 8    1 1  10 3f  14 0 1
4 1 1    1 8  10 3f  14 0 1
4 1 310  1 8  10 3f  14 0 0
4 1 1    1 1  13 3f  14 0 1
4 1 2    1 8  13 3f  14 0 1
4 1 1410 1 8  13 3f  14 0 0
4 1 1    1 1  1f 3f  14 0 1
4 1 1    1 8  1f 3f  14 0 1
4 1 208  1 8  1f 3f  14 0 0
4 1 4    1 1  1f 3f  14 0 1
// incoming call, accepted
5 3 5    2 20 1f 168 d  0 1
5 1 8    2 21 1f 176 14 0 1
5 1 1    2 21 1f 176 14 3 0
5 3 1    4 26 1f 1e9 c  0 1
// ring timeout
6 3 6    1 0  1f 34  b  0 1
6 3 5    2 20 1f 168 d  0 1
6 4 1    1 0  1f 34  b  2 1
0 ff 0   0 0  0  0   0  0 0

//--- testbench/phone_ui_tb.sv
`timescale 1ns/1ps

// file driven testbench for the desk phone ui
module phone_ui_tb import phone_ui_pkg::*; ();

	localparam int step_cols     = 10;  // words per stimulus line
	localparam int max_steps     = 64;
	localparam int state_timeout = 40;  // cycles allowed for the ring timeout
	localparam logic [15:0] end_action = 16'h00ff;

	logic        clk = 1'b0;
	logic        rst;
	btn_t        buttons;
	logic [7:0]  switches;
	app_evt_t    app_evt;
	call_state_t call_state;
	menu_item_t  menu_item;
	net_cmd_t    net_cmd;
	logic [7:0]  dial_number;
	logic [4:0]  volume;
	text_ref_t   text_ref;
	logic        txt_start;

	logic [15:0] stim_mem [0:step_cols*max_steps-1];

	int       cmd_cnt;  // running pulse counts kept by the monitor
	int       txt_cnt;
	net_cmd_t last_cmd; // code of the latest command pulse
	int       test_errors;
	int       total_errors;
	int       checks;
	int       tests_run;
	int       tests_failed;
	logic [7:0] sw_val;   // switches as last driven

	phone_ui_top #(.tick_div(4), .ring_ticks(5)) dut_i (
		.clk(clk), .rst(rst), .buttons(buttons), .switches(switches),
		.app_evt(app_evt), .call_state(call_state), .menu_item(menu_item),
		.net_cmd(net_cmd), .dial_number(dial_number), .volume(volume),
		.text_ref(text_ref), .txt_start(txt_start)
	);

	always #20 clk = ~clk; // 40 ns period

	//////////////////////////////////////////////////
	// pulse monitor sampling mid cycle
	//////////////////////////////////////////////////

	initial begin
		cmd_cnt  = 0;
		txt_cnt  = 0;
		last_cmd = cmd_none;
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (net_cmd != cmd_none) begin
				cmd_cnt++;
				last_cmd = net_cmd;
			end
			if (txt_start)
				txt_cnt++; // one per reload
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic string test_name(input int id);
		case (id)
			1: return "reset and init";
			2: return "main menu";
			3: return "outgoing call";
			4: return "volume";
			5: return "incoming call";
			6: return "ring timeout";
			default: return "unnamed";
		endcase
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	// starts and ends on a rising edge
	task automatic press_button(input btn_t b, input int hold);
		buttons <= b;
		repeat (hold) @(posedge clk);
		buttons <= '0;
		repeat (3) @(posedge clk); // released long enough for next edge
	endtask

	task automatic send_event(input app_evt_t e);
		app_evt <= e;
		@(posedge clk);
		app_evt <= evt_none; // level for one cycle only
		repeat (2) @(posedge clk);
	endtask

	task automatic wait_for_state(input call_state_t target);
		int n;
		n = 0;
		@(negedge clk);
		while (call_state != target && n < state_timeout) begin
			@(negedge clk);
			n++;
		end
		checks++;
		assert (call_state == target) else begin
			$display("timeout: call_state stayed %s and never reached %s within %0d cycles",
				call_state.name(), target.name(), state_timeout);
			test_errors++;
		end
		repeat (3) @(posedge clk); // let the text reload settle
	endtask

	task automatic run_step(input int idx);
		logic [15:0] act;
		logic [15:0] arg;
		int base;
		int reps;
		int cmd_base;
		int txt_base;
		base = idx * step_cols;
		act  = stim_mem[base + 1];
		arg  = stim_mem[base + 2];
		@(posedge clk);
		cmd_base = cmd_cnt;
		txt_base = txt_cnt;
		case (act)
			16'h0: ; // check only
			16'h1: begin
				reps = (arg[15:8] == 8'd0) ? 1 : int'(arg[15:8]);
				repeat (reps) press_button(btn_t'(arg[4:0]), 3);
			end
			16'h2: begin
				switches <= arg[7:0];
				sw_val = arg[7:0];
				repeat (2) @(posedge clk);
			end
			16'h3: send_event(app_evt_t'(arg[2:0]));
			16'h4: wait_for_state(call_state_t'(arg[2:0]));
			16'h5: press_button(btn_t'(arg[4:0]), 12); // long hold
			default: begin
				$display("stimulus line %0d has an unknown action %0h", idx, act);
				test_errors++;
			end
		endcase
		@(negedge clk);
		check_value("call_state", call_state, stim_mem[base + 3]);
		check_value("menu_item", menu_item, stim_mem[base + 4]);
		check_value("volume", volume, stim_mem[base + 5]);
		check_value("text_ref.addr", text_ref.addr, stim_mem[base + 6]);
		check_value("text_ref.len", text_ref.len, stim_mem[base + 7]);
		check_value("net_cmd pulses", cmd_cnt - cmd_base, (stim_mem[base + 8] != 0) ? 1 : 0);
		if (stim_mem[base + 8] != 0 && cmd_cnt - cmd_base == 1)
			check_value("net_cmd", last_cmd, stim_mem[base + 8]);
		if (stim_mem[base + 8] == 16'(cmd_make_call))
			check_value("dial_number", dial_number, sw_val); // captured with the command
		check_value("txt_start pulses", txt_cnt - txt_base, stim_mem[base + 9]);
	endtask

	task automatic finish_test(input int id);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d, %s: passed", id, test_name(id));
		end else begin
			$display("test %0d, %s: failed, %0d errors", id, test_name(id), test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int idx;
		int cur_test;
		logic done;
		rst          = 1'b1;
		buttons      = '0;
		switches     = '0;
		app_evt      = evt_none;
		sw_val       = '0;
		test_errors  = 0;
		total_errors = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		$readmemh("testbench/phone_ui_stimulus.txt", stim_mem);
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		idx      = 0;
		cur_test = -1;
		done     = 1'b0;
		while (!done && idx < max_steps) begin
			if (stim_mem[idx*step_cols + 1] == end_action) begin
				done = 1'b1;
			end else begin
				if (int'(stim_mem[idx*step_cols]) != cur_test) begin
					if (cur_test >= 0)
						finish_test(cur_test);
					cur_test = stim_mem[idx*step_cols];
				end
				run_step(idx);
				idx++;
			end
		end
		if (cur_test >= 0)
			finish_test(cur_test);
		assert (done) else begin
			$display("stimulus file has no end line after %0d steps", idx);
			total_errors++;
		end

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, total_errors);
		if (total_errors == 0 && tests_run > 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
